// File: common/isa_pkg.sv
package isa_pkg;

  // opcode fields matched against the top bits of the word
  localparam logic [16:0] OPC_ADD_W   = 17'h00020;
  localparam logic [16:0] OPC_SUB_W   = 17'h00022;
  localparam logic [16:0] OPC_INVTLB  = 17'h00C93;
  localparam logic [9:0]  OPC_ADDI_W  = 10'h00A;
  localparam logic [9:0]  OPC_LD_W    = 10'h0A2;
  localparam logic [9:0]  OPC_ST_W    = 10'h0A6;
  localparam logic [6:0]  OPC_LU12I_W = 7'h0A;
  localparam logic [5:0]  OPC_BEQ     = 6'h16;
  localparam logic [5:0]  OPC_BL      = 6'h15;
  localparam logic [5:0]  OPC_JIRL    = 6'h13;

  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } inst_fields_t;

  // raw view for matching and field view for register extraction
  typedef union packed {
    logic [31:0]  raw;
    inst_fields_t f;
  } inst_u;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_ADDI,
    OP_LU12I,
    OP_LD,
    OP_ST,
    OP_BEQ,
    OP_BL,
    OP_JIRL,
    OP_INVTLB
  } op_e;

  typedef enum logic [1:0] {R0_NONE, R0_RK, R0_RD} r0_sel_e;
  typedef enum logic {R1_NONE, R1_RJ} r1_sel_e;
  typedef enum logic [1:0] {W_NONE, W_RD, W_BL1} w_sel_e;

  typedef struct packed {
    op_e     op;
    r0_sel_e r0_sel;
    r1_sel_e r1_sel;
    w_sel_e  w_sel;
    logic    invtlb_en;
  } decode_info_t;

  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

  // fetch exception code where zero means none
  typedef logic [1:0] excp_t;

  localparam excp_t EXCP_NONE = 2'd0;

  typedef struct packed {
    logic [31:0]            pc;
    isa_pkg::inst_u [1:0]   inst;
    logic [1:0]             mask;
    excp_t                  excp;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]           pc;
    isa_pkg::decode_info_t di;
    isa_pkg::reg_info_t    ri;
    excp_t                 fetch_excp;
    logic                  ine;
  } ctrl_pack_t;

  // lane 0 always holds the first valid instruction
  typedef struct packed {
    ctrl_pack_t [1:0] p;
    logic [1:0]       mask;
  } issue_pkt_t;

endpackage

// File: design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             inp_valid_i,
  output logic             inp_ready_o,
  input  logic [WIDTH-1:0] inp_i,
  output logic             oup_valid_o,
  input  logic             oup_ready_i,
  output logic [WIDTH-1:0] oup_o
);

  logic             valid_q;
  logic [WIDTH-1:0] data_q;

  // accept when empty or when the held word leaves this cycle
  assign inp_ready_o = !valid_q || oup_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (inp_ready_o)
    begin
      valid_q <= inp_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (inp_valid_i && inp_ready_o)
    begin
      data_q <= inp_i;
    end
  end

  assign oup_valid_o = valid_q;
  assign oup_o       = data_q;

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [WIDTH-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [WIDTH-1:0] out_data_o
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // wraps for depths that are not a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count != CW'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];
  assign do_wr       = in_valid_i && in_ready_o;
  assign do_rd       = out_valid_o && out_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd)
      begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CW'(do_wr) - CW'(do_rd);
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= in_data_i;
    end
  end

endmodule

// File: frontend/fe_decoder.sv
`timescale 1ns/1ps

module fe_decoder (
  input  isa_pkg::inst_u        inst_i,
  output isa_pkg::decode_info_t info_o,
  output logic                  decode_err_o
);
  import isa_pkg::*;

  function automatic decode_info_t mk_info(
    input op_e     op,
    input r0_sel_e r0,
    input r1_sel_e r1,
    input w_sel_e  w
  );
    decode_info_t ret;
    ret           = '0;
    ret.op        = op;
    ret.r0_sel    = r0;
    ret.r1_sel    = r1;
    ret.w_sel     = w;
    return ret;
  endfunction

  always_comb
  begin
    info_o       = '0;
    decode_err_o = 1'b0;
    if (inst_i.raw[31:15] == OPC_ADD_W)
    begin
      info_o = mk_info(OP_ADD, R0_RK, R1_RJ, W_RD);
    end
    else if (inst_i.raw[31:15] == OPC_SUB_W)
    begin
      info_o = mk_info(OP_SUB, R0_RK, R1_RJ, W_RD);
    end
    else if (inst_i.raw[31:22] == OPC_ADDI_W)
    begin
      info_o = mk_info(OP_ADDI, R0_NONE, R1_RJ, W_RD);
    end
    else if (inst_i.raw[31:25] == OPC_LU12I_W)
    begin
      info_o = mk_info(OP_LU12I, R0_NONE, R1_NONE, W_RD);
    end
    else if (inst_i.raw[31:22] == OPC_LD_W)
    begin
      info_o = mk_info(OP_LD, R0_NONE, R1_RJ, W_RD);
    end
    else if (inst_i.raw[31:22] == OPC_ST_W)
    begin
      // store data comes from rd
      info_o = mk_info(OP_ST, R0_RD, R1_RJ, W_NONE);
    end
    else if (inst_i.raw[31:26] == OPC_BEQ)
    begin
      info_o = mk_info(OP_BEQ, R0_RD, R1_RJ, W_NONE);
    end
    else if (inst_i.raw[31:26] == OPC_BL)
    begin
      // link register is r1
      info_o = mk_info(OP_BL, R0_NONE, R1_NONE, W_BL1);
    end
    else if (inst_i.raw[31:26] == OPC_JIRL)
    begin
      info_o = mk_info(OP_JIRL, R0_NONE, R1_RJ, W_RD);
    end
    else if (inst_i.raw[31:15] == OPC_INVTLB)
    begin
      info_o           = mk_info(OP_INVTLB, R0_RK, R1_RJ, W_NONE);
      info_o.invtlb_en = 1'b1;
    end
    else
    begin
      decode_err_o = 1'b1;
    end
  end

endmodule

// File: frontend/fe_decode_lane.sv
`timescale 1ns/1ps

module fe_decode_lane (
  input  isa_pkg::inst_u       inst_i,
  input  logic [31:0]          pc_i,
  input  pipe_pkg::excp_t      excp_i,
  output pipe_pkg::ctrl_pack_t ctrl_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  decode_info_t di;
  logic         decode_err;
  reg_info_t    ri;

  fe_decoder u_decoder (
    .inst_i      (inst_i),
    .info_o      (di),
    .decode_err_o(decode_err)
  );

  // unselected ports read r0
  always_comb
  begin
    ri = '0;
    case (di.r0_sel)
      R0_RK:   ri.r_reg[0] = inst_i.f.rk;
      R0_RD:   ri.r_reg[0] = inst_i.f.rd;
      default: ri.r_reg[0] = 5'd0;
    endcase
    case (di.r1_sel)
      R1_RJ:   ri.r_reg[1] = inst_i.f.rj;
      default: ri.r_reg[1] = 5'd0;
    endcase
    case (di.w_sel)
      W_RD:    ri.w_reg = inst_i.f.rd;
      W_BL1:   ri.w_reg = 5'd1;
      default: ri.w_reg = 5'd0;
    endcase
  end

  // invtlb op codes above 6 are reserved
  assign ctrl_o.ine = (excp_i == EXCP_NONE) &&
                      (decode_err || (di.invtlb_en && (inst_i.f.rd >= 5'd7)));

  assign ctrl_o.pc         = pc_i;
  assign ctrl_o.di         = di;
  assign ctrl_o.ri         = ri;
  assign ctrl_o.fetch_excp = excp_i;

endmodule

// File: frontend/fe_decode_stage.sv
`timescale 1ns/1ps

module fe_decode_stage (
  input  pipe_pkg::fetch_pkt_t pkt_i,
  output pipe_pkg::issue_pkt_t issue_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  inst_u [1:0]      lane_inst;
  logic [1:0][31:0] lane_pc;
  logic [1:0]       aligned_mask;
  ctrl_pack_t [1:0] lane_ctrl;

  // a lone slot 1 moves down to lane 0
  always_comb
  begin
    lane_inst    = pkt_i.inst;
    aligned_mask = pkt_i.mask;
    if (!pkt_i.mask[0])
    begin
      lane_inst[0] = pkt_i.inst[1];
      aligned_mask = 2'b01;
    end
  end

  assign lane_pc[0] = pkt_i.pc;
  assign lane_pc[1] = {pkt_i.pc[31:3], 1'b1, pkt_i.pc[1:0]};

  for (genvar i = 0; i < 2; i++)
  begin : g_lane
    fe_decode_lane u_lane (
      .inst_i(lane_inst[i]),
      .pc_i  (lane_pc[i]),
      .excp_i(pkt_i.excp),
      .ctrl_o(lane_ctrl[i])
    );
  end

  assign issue_o.p    = lane_ctrl;
  assign issue_o.mask = aligned_mask;

endmodule

// File: frontend/fe_decode_top.sv
`timescale 1ns/1ps

module fe_decode_top #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  pipe_pkg::fetch_pkt_t fetch_pkt_i,
  output logic                 issue_valid_o,
  input  logic                 issue_ready_i,
  output pipe_pkg::issue_pkt_t issue_pkt_o
);
  import pipe_pkg::*;

  localparam int unsigned PKT_W = $bits(issue_pkt_t);

  issue_pkt_t dec_pkt;
  issue_pkt_t pr_pkt;
  logic       pr_valid;
  logic       pr_ready;

  fe_decode_stage u_stage (
    .pkt_i  (fetch_pkt_i),
    .issue_o(dec_pkt)
  );

  pipe_reg #(.WIDTH(PKT_W)) u_pipe_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .inp_valid_i(fetch_valid_i),
    .inp_ready_o(fetch_ready_o),
    .inp_i      (dec_pkt),
    .oup_valid_o(pr_valid),
    .oup_ready_i(pr_ready),
    .oup_o      (pr_pkt)
  );

  sync_fifo #(.WIDTH(PKT_W), .DEPTH(FIFO_DEPTH)) u_issue_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .in_valid_i (pr_valid),
    .in_ready_o (pr_ready),
    .in_data_i  (pr_pkt),
    .out_valid_o(issue_valid_o),
    .out_ready_i(issue_ready_i),
    .out_data_o (issue_pkt_o)
  );

endmodule

// File: tests/fe_decode_assertions.sv
`timescale 1ns/1ps

module fe_decode_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 flush_i,
  input logic                 fetch_valid_i,
  input pipe_pkg::fetch_pkt_t fetch_pkt_i,
  input logic                 issue_valid_o,
  input logic                 issue_ready_i,
  input pipe_pkg::issue_pkt_t issue_pkt_o
);

  int unsigned fail_count = 0;

  a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !issue_valid_o)
    else
    begin
      fail_count++;
      $error("issue valid high in the cycle after reset");
    end

  // stalled output must hold until taken or flushed
  a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_valid_o && !issue_ready_i && !flush_i) |=> (issue_valid_o && $stable(issue_pkt_o)))
    else
    begin
      fail_count++;
      $error("issue valid or payload changed while stalled");
    end

  a_issue_mask: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_o |-> (issue_pkt_o.mask == 2'b01 || issue_pkt_o.mask == 2'b11))
    else
    begin
      fail_count++;
      $error("issue mask not aligned");
    end

  a_fetch_mask: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_i |-> (fetch_pkt_i.mask != 2'b00))
    else
    begin
      fail_count++;
      $error("fetch packet with empty mask");
    end

endmodule

bind fe_decode_top fe_decode_assertions u_assert (.*);

// File: tests/tb_fe_decode.sv
`timescale 1ns/1ps

module tb_fe_decode;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int unsigned MAX_CYCLES = 3000;

  logic        clk;
  logic        rst_n;
  logic        flush_i;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  fetch_pkt_t  fetch_pkt_i;
  logic        issue_valid_o;
  logic        issue_ready_i;
  issue_pkt_t  issue_pkt_o;
  int unsigned cycles = 0;
  issue_pkt_t  exp_q[$];

  fe_decode_top #(.FIFO_DEPTH(8)) UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      abort_run("timeout, the DUT stopped making progress");
  end

  // expected lane contents straight from the instruction table
  function automatic ctrl_pack_t exp_lane(input logic [31:0] w, input logic [31:0] pc,
                                          input excp_t excp);
    decode_info_t di;
    logic         unknown;
    ctrl_pack_t   c;
    di      = '0;
    unknown = 1'b0;
    case (1'b1)
      (w[31:15] == 17'h00020): di = '{OP_ADD, R0_RK, R1_RJ, W_RD, 1'b0};
      (w[31:15] == 17'h00022): di = '{OP_SUB, R0_RK, R1_RJ, W_RD, 1'b0};
      (w[31:22] == 10'h00A):   di = '{OP_ADDI, R0_NONE, R1_RJ, W_RD, 1'b0};
      (w[31:25] == 7'h0A):     di = '{OP_LU12I, R0_NONE, R1_NONE, W_RD, 1'b0};
      (w[31:22] == 10'h0A2):   di = '{OP_LD, R0_NONE, R1_RJ, W_RD, 1'b0};
      (w[31:22] == 10'h0A6):   di = '{OP_ST, R0_RD, R1_RJ, W_NONE, 1'b0};
      (w[31:26] == 6'h16):     di = '{OP_BEQ, R0_RD, R1_RJ, W_NONE, 1'b0};
      (w[31:26] == 6'h15):     di = '{OP_BL, R0_NONE, R1_NONE, W_BL1, 1'b0};
      (w[31:26] == 6'h13):     di = '{OP_JIRL, R0_NONE, R1_RJ, W_RD, 1'b0};
      (w[31:15] == 17'h00C93): di = '{OP_INVTLB, R0_RK, R1_RJ, W_NONE, 1'b1};
      default:                 unknown = 1'b1;
    endcase
    c             = '0;
    c.pc          = pc;
    c.di          = di;
    c.fetch_excp  = excp;
    c.ri.r_reg[0] = (di.r0_sel == R0_RK) ? w[14:10] : (di.r0_sel == R0_RD) ? w[4:0] : 5'd0;
    c.ri.r_reg[1] = (di.r1_sel == R1_RJ) ? w[9:5] : 5'd0;
    c.ri.w_reg    = (di.w_sel == W_RD) ? w[4:0] : (di.w_sel == W_BL1) ? 5'd1 : 5'd0;
    c.ine         = (excp == 2'd0) && (unknown || (di.op == OP_INVTLB && w[4:0] >= 5'd7));
    return c;
  endfunction

  function automatic issue_pkt_t exp_issue(input fetch_pkt_t f);
    issue_pkt_t e;
    e.p[0] = exp_lane(f.mask[0] ? f.inst[0].raw : f.inst[1].raw, f.pc, f.excp);
    e.p[1] = exp_lane(f.inst[1].raw, f.pc | 32'h4, f.excp);
    e.mask = f.mask[0] ? f.mask : 2'b01;
    return e;
  endfunction

  // k of 0..9 picks a table entry and anything else gives an unknown word
  function automatic logic [31:0] make_word(input int k);
    logic [31:0] r;
    r = $urandom();
    case (k)
      0:       return {17'h00020, r[14:0]};
      1:       return {17'h00022, r[14:0]};
      2:       return {10'h00A, r[21:0]};
      3:       return {7'h0A, r[24:0]};
      4:       return {10'h0A2, r[21:0]};
      5:       return {10'h0A6, r[21:0]};
      6:       return {6'h16, r[25:0]};
      7:       return {6'h15, r[25:0]};
      8:       return {6'h13, r[25:0]};
      9:       return {17'h00C93, r[14:0]};
      default: return {6'h3F, r[25:0]};
    endcase
  endfunction

  function automatic fetch_pkt_t mk_pkt(input logic [31:0] w0, input logic [31:0] w1,
                                        input logic [1:0] mask, input excp_t excp);
    fetch_pkt_t f;
    f.pc          = $urandom();
    f.inst[0].raw = w0;
    f.inst[1].raw = w1;
    f.mask        = mask;
    f.excp        = excp;
    return f;
  endfunction

  function automatic fetch_pkt_t rand_pkt();
    return mk_pkt(make_word($urandom_range(10, 0)), make_word($urandom_range(10, 0)),
                  2'($urandom_range(3, 1)), 2'($urandom_range(3, 0)));
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_pack_t got, input ctrl_pack_t exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_issue(input string name, input issue_pkt_t got, input issue_pkt_t exp);
    check_ctrl({name, ".p[0]"}, got.p[0], exp.p[0]);
    check_ctrl({name, ".p[1]"}, got.p[1], exp.p[1]);
    if (got.mask !== exp.mask)
    begin
      $display("ERROR %s.mask got %h expected %h", name, got.mask, exp.mask);
      abort_run("value mismatch");
    end
  endtask

  // keeps the offered packet until the DUT takes it
  task automatic wait_fetch_taken();
    logic taken;
    do
    begin
      @(negedge clk);
      taken = fetch_ready_o;
      @(posedge clk);
    end while (!taken);
    fetch_valid_i <= 1'b0;
  endtask

  task automatic send_pkt(input fetch_pkt_t p);
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_pkt_i   <= p;
    wait_fetch_taken();
  endtask

  // needs issue_ready_i high so the checked packet leaves at the next edge
  task automatic expect_issue(input issue_pkt_t exp);
    @(negedge clk);
    while (!issue_valid_o)
      @(negedge clk);
    check_issue("issue_pkt_o", issue_pkt_o, exp);
    @(posedge clk);
  endtask

  task automatic send_and_expect(input fetch_pkt_t p);
    send_pkt(p);
    expect_issue(exp_issue(p));
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
  endtask

  task automatic test_each_instr();
    for (int k = 0; k < 11; k++)
      send_and_expect(mk_pkt(make_word(k), make_word((k + 1) % 11), 2'b11, 2'd0));
  endtask

  task automatic test_alignment();
    for (int i = 0; i < 6; i++)
      send_and_expect(mk_pkt(make_word(i), make_word(i + 4), 2'((i % 3) + 1), 2'd0));
  endtask

  task automatic test_ine();
    send_and_expect(mk_pkt({17'h00C93, 5'd3, 5'd4, 5'd7}, make_word(0), 2'b11, 2'd0));
    send_and_expect(mk_pkt({17'h00C93, 5'd3, 5'd4, 5'd6}, make_word(1), 2'b11, 2'd0));
    send_and_expect(mk_pkt(make_word(2), {17'h00C93, 5'd9, 5'd2, 5'd31}, 2'b10, 2'd0));
    send_and_expect(mk_pkt(32'hFFFF_FFFF, make_word(10), 2'b11, 2'd0));
    send_and_expect(mk_pkt(32'hFFFF_FFFF, {17'h00C93, 5'd1, 5'd1, 5'd9}, 2'b11, 2'd2));
  endtask

  task automatic test_backpressure();
    int         n;
    logic       stalled;
    fetch_pkt_t p;
    n       = 0;
    stalled = 1'b0;
    @(posedge clk);
    issue_ready_i <= 1'b0;
    while (!stalled && n < 20)
    begin
      p = rand_pkt();
      fetch_valid_i <= 1'b1;
      fetch_pkt_i   <= p;
      @(negedge clk);
      if (fetch_ready_o)
      begin
        exp_q.push_back(exp_issue(p));
        n++;
      end
      else
      begin
        stalled = 1'b1;
      end
      @(posedge clk);
    end
    if (n != 9)
      abort_run($sformatf("%0d packets accepted before the stall, expected 9", n));
    // the refused packet stays offered and drains last
    exp_q.push_back(exp_issue(p));
    issue_ready_i <= 1'b1;
    fork
      wait_fetch_taken();
      while (exp_q.size() > 0)
        expect_issue(exp_q.pop_front());
    join
    @(negedge clk);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
  endtask

  task automatic test_flush();
    @(posedge clk);
    issue_ready_i <= 1'b0;
    repeat (3) send_pkt(rand_pkt());
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i       <= 1'b0;
    issue_ready_i <= 1'b1;
    @(negedge clk);
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    send_and_expect(rand_pkt());
    repeat (3)
    begin
      @(negedge clk);
      check_bit("issue_valid_o", issue_valid_o, 1'b0);
    end
  endtask

  initial
  begin
    void'($urandom(32'hbc3f_3961));
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pkt_i   = '0;
    issue_ready_i = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_each_instr();
    test_alignment();
    test_ine();
    test_backpressure();
    test_flush();
    if (UUT.u_assert.fail_count == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
    begin
      abort_run("bound assertions reported failures");
    end
  end

endmodule

// File: filelist.f
common/isa_pkg.sv
common/pipe_pkg.sv
design/pipe_reg.sv
design/sync_fifo.sv
frontend/fe_decoder.sv
frontend/fe_decode_lane.sv
frontend/fe_decode_stage.sv
frontend/fe_decode_top.sv
tests/fe_decode_assertions.sv
tests/tb_fe_decode.sv
